// File: i2cTrace.txt
# ctrl baud data tgtAck tgtByte booted pause | expXfer expData expAck  (all hex)
# ctrl bits: 8=START 4=WR 2=STOP 1=EN; tgtAck 0 = target acknowledges
F 0004 A5 0 00 1 0 1 A5 0
F 0002 3C 1 00 1 0 1 3C 1
B 0006 00 0 C3 1 0 1 C3 0
D 0004 81 0 00 1 0 1 81 0
7 0004 7E 0 00 1 0 1 7E 0
3 0002 00 0 5A 1 0 1 5A 0
F 0004 99 0 00 1 1 0 99 0
F 0004 66 0 00 0 0 0 66 0
E 0004 55 0 00 1 0 0 55 0
F 000A E7 0 00 1 0 1 E7 0
B 0008 00 1 96 1 0 1 96 0
F 0004 00 1 00 1 0 1 00 1

// File: project.f
+incdir+.
i2cRegPkg.sv
i2cBusPkg.sv
i2cRegFile.sv
i2cBitEngine.sv
i2cPinDriver.sv
i2cPeripheral.sv
i2cPeripheralTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
TOP       = i2cPeripheralTb
FILELIST  = project.f
LOG       = sim.log
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: i2cPeripheralTb.sv
/* I2C master peripheral testbench
   Trace-driven register accesses, a target bus model and result checks */
`timescale 1ns/1ns
`include "i2c_consts.svh"

module i2cPeripheralTb;
	import i2cRegPkg::*;

	memAddrT  i_memAddr;
	memWordT  i_memDataIn, o_memDataOut;
	logic     i_memWrEn, i_smIsBooted, i_smStartPause, o_smNowPaused;
	logic     i_pinSDAIn, o_pinSCLDir, o_pinSDADir, o_intI2C, i_clk, i_arstN;

	int       tr[32][10];                  // Trace rows, columns as in the file
	int       nTests, testIdx, seenIdx, errs, failCnt, cycleCnt, cycleLimit;
	logic     limitSet;
	// Current test, seen by the target model
	logic [3:0] curCtrl;
	logic [7:0] curTgtByte;
	logic     curTgtAck, curIsWr;
	// Target model state
	logic     sclLine, sdaLine, sclPrev, sdaPrev, tgtPull, tgtActive;
	logic     startSeen, stopSeen, ackLine;
	logic [3:0] rxCnt, driveIdx;
	logic [2:0] bitSel;
	logic [7:0] rxByte;
	int       intCnt, activity;

	i2cPeripheral UUT (.*);

	// ------------------------------------------------------------------------
	// Clock and watchdog
	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycleCnt++;
		if (limitSet && cycleCnt > cycleLimit) begin
			$display("Timeout: run exceeded %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Target model, open-drain lines
	assign sclLine    = ~o_pinSCLDir;
	assign sdaLine    = ~o_pinSDADir & ~tgtPull;
	assign i_pinSDAIn = sdaLine;

	always_comb begin
		bitSel  = 3'd7 - driveIdx[2:0];
		tgtPull = 1'b0;
		if (tgtActive && driveIdx < 4'd8 && !curIsWr)
			tgtPull = ~curTgtByte[bitSel];     // Read bits, MSB first
		else if (tgtActive && driveIdx == 4'd8 && curIsWr)
			tgtPull = ~curTgtAck;              // 0 in the trace means ACK
	end

	// Lines sampled mid-cycle, away from the DUT's edges
	always @(negedge i_clk) begin
		if (testIdx != seenIdx) begin
			seenIdx   = testIdx;               // New test, clear the model
			rxCnt     = 4'd0;
			driveIdx  = 4'd0;
			rxByte    = 8'h00;
			ackLine   = 1'b1;
			startSeen = 1'b0;
			stopSeen  = 1'b0;
			intCnt    = 0;
			activity  = 0;
			tgtActive = ~sclLine;              // Bus left held by last byte
		end else begin
			if (o_intI2C)
				intCnt++;
			if (o_pinSCLDir || o_pinSDADir)
				activity++;
			if (sclPrev && sclLine && sdaPrev && !sdaLine) begin
				startSeen = 1'b1;              // Bits restart after START
				rxCnt     = 4'd0;
				driveIdx  = 4'd0;
			end
			if (sclPrev && sclLine && !sdaPrev && sdaLine)
				stopSeen = 1'b1;
			if (!sclPrev && sclLine) begin
				if (rxCnt < 4'd8)
					rxByte = {rxByte[6:0], sdaLine};
				else if (rxCnt == 4'd8)
					ackLine = sdaLine;         // ACK slot level
				rxCnt++;
			end
			if (sclPrev && !sclLine) begin
				tgtActive = 1'b1;
				driveIdx  = rxCnt;             // Next bit goes out on SCL low
			end
		end
		sclPrev = sclLine;
		sdaPrev = sdaLine;
	end

	// ------------------------------------------------------------------------
	// Bus access and reporting
	task automatic writeReg(input memAddrT addr, input memWordT data);
		@(posedge i_clk);
		i_memAddr   <= addr;
		i_memDataIn <= data;
		i_memWrEn   <= 1'b1;
		@(posedge i_clk);
		i_memWrEn   <= 1'b0;
	endtask

	task automatic readReg(input memAddrT addr, output memWordT data);
		@(posedge i_clk);
		i_memAddr <= addr;
		@(negedge i_clk);
		data = o_memDataOut;
	endtask

	task automatic reportValue(input string sig, input logic [15:0] expv, input logic [15:0] got);
		$display("ERROR t=%0t %s expected=%h got=%h", $time, sig, expv, got);
		errs++;
	endtask

	task automatic reportText(input string msg);
		$display("Test %0d failed at t=%0t: %s", testIdx, $time, msg);
		errs++;
	endtask

	// One trace row
	task automatic runTest(input int i);
		memWordT rd;
		int      half, n;
		logic    expAck, lineAck;
		logic [7:0] expData;
		testIdx++;
		errs       = 0;
		curCtrl    = 4'(tr[i][0]);
		curTgtAck  = 1'(tr[i][3]);
		curTgtByte = 8'(tr[i][4]);
		curIsWr    = curCtrl[`I2C_CTRL_WR];
		expData    = 8'(tr[i][8]);
		expAck     = 1'(tr[i][9]);
		half       = (tr[i][1] >> 1) + 1;
		writeReg(`I2C_ADDR_CTRL, {12'd0, curCtrl});
		writeReg(`I2C_ADDR_BAUD, 16'(tr[i][1]));
		@(posedge i_clk);
		i_smIsBooted   <= 1'(tr[i][5]);
		i_smStartPause <= 1'(tr[i][6]);
		if (tr[i][6] != 0) begin
			n = 0;
			while (!o_smNowPaused && n < 20) begin
				@(negedge i_clk);
				n++;
			end
			if (!o_smNowPaused)
				reportText("o_smNowPaused did not rise while idle");
		end
		// Register layout, ACK bit masked out
		readReg(`I2C_ADDR_CTRL, rd);
		if ((rd & 16'hBFFF) != {4'h8, 8'h00, curCtrl})
			reportValue("o_memDataOut[CTRL]", {4'h8, 8'h00, curCtrl}, rd & 16'hBFFF);
		readReg(`I2C_ADDR_BAUD, rd);
		if (rd != (16'(tr[i][1]) & 16'hFFFE))
			reportValue("o_memDataOut[BAUD]", 16'(tr[i][1]) & 16'hFFFE, rd);
		readReg(2'd3, rd);
		if (rd != 16'h0000)
			reportValue("o_memDataOut[3]", 16'h0000, rd);
		writeReg(`I2C_ADDR_DATA, {8'h00, 8'(tr[i][2])});
		readReg(`I2C_ADDR_DATA, rd);
		if (rd != {8'h00, 8'(tr[i][2])})
			reportValue("o_memDataOut[DATA]", {8'h00, 8'(tr[i][2])}, rd);
		if (tr[i][7] != 0) begin
			@(posedge i_clk);
			while (intCnt == 0)
				@(posedge i_clk);
			repeat (5) @(posedge i_clk);
			if (intCnt != 1)
				reportText("o_intI2C did not pulse exactly once");
			if (rxByte != expData)
				reportValue("targetByte", {8'h00, expData}, {8'h00, rxByte});
			lineAck = curIsWr ? curTgtAck : 1'b0;   // Master ACKs reads
			if (ackLine != lineAck)
				reportValue("ackSlotSDA", {15'd0, lineAck}, {15'd0, ackLine});
			if (startSeen != curCtrl[`I2C_CTRL_START])
				reportText("START seen does not match CTRL");
			if (stopSeen != curCtrl[`I2C_CTRL_STOP])
				reportText("STOP seen does not match CTRL");
			readReg(`I2C_ADDR_CTRL, rd);
			if (rd != {1'b1, expAck, 10'd0, curCtrl})
				reportValue("o_memDataOut[STATUS]", {1'b1, expAck, 10'd0, curCtrl}, rd);
			readReg(`I2C_ADDR_DATA, rd);
			if (rd != {8'h00, expData})
				reportValue("o_memDataOut[DATA]", {8'h00, expData}, rd);
		end else begin
			repeat (22 * half + 10) @(posedge i_clk);   // One full byte time
			if (intCnt != 0)
				reportText("interrupt raised with no transfer allowed");
			if (activity != 0)
				reportText("pin activity with no transfer allowed");
			readReg(`I2C_ADDR_CTRL, rd);
			if (!rd[`I2C_STAT_IDLE])
				reportText("idle status bit dropped");
			if (tr[i][6] != 0 && !o_smNowPaused)
				reportText("o_smNowPaused fell during the request");
		end
		@(posedge i_clk);
		i_smStartPause <= 1'b0;
		i_smIsBooted   <= 1'b1;
		repeat (2) @(posedge i_clk);
		if (errs != 0)
			failCnt++;
		$display("Test %0d ctrl=%h data=%h: %s", testIdx, curCtrl, 8'(tr[i][2]),
			(errs == 0) ? "PASS" : "FAIL");
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	initial begin
		string line;
		int    fd, gap;
		i_memAddr      = 2'd0;
		i_memDataIn    = 16'h0000;
		i_memWrEn      = 1'b0;
		i_smIsBooted   = 1'b1;
		i_smStartPause = 1'b0;
		i_arstN        = 1'b0;
		testIdx = 0;
		seenIdx = 0;
		failCnt = 0;
		cycleCnt = 0;
		limitSet = 1'b0;
		nTests = 0;
		sclPrev = 1'b1;
		sdaPrev = 1'b1;
		void'($urandom(32'h8ff7_fee5));
		fd = $fopen("i2cTrace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file i2cTrace.txt");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			while ($fgets(line, fd) != 0 && nTests < 32) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", tr[nTests][0],
					tr[nTests][1], tr[nTests][2], tr[nTests][3], tr[nTests][4],
					tr[nTests][5], tr[nTests][6], tr[nTests][7], tr[nTests][8],
					tr[nTests][9]) == 10)
					nTests++;
			end
			$fclose(fd);
			cycleLimit = 50;                   // Reset time
			for (int i = 0; i < nTests; i++)
				cycleLimit += 22 * ((tr[i][1] >> 1) + 1) + 50;
			limitSet = 1'b1;
			repeat (10) @(posedge i_clk);
			i_arstN <= 1'b1;
			for (int i = 0; i < nTests; i++) begin
				gap = $urandom % 4;            // Idle gap between tests
				repeat (gap) @(posedge i_clk);
				runTest(i);
			end
			$display("Tests run %0d, passed %0d, failed %0d", nTests, nTests - failCnt, failCnt);
			if (failCnt == 0 && nTests > 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

// File: i2cPeripheral.sv
/* I2C master peripheral top
   Register file, bit engine and pin driver wired together */
`timescale 1ns/1ns

module i2cPeripheral (
	input  i2cRegPkg::memAddrT i_memAddr,
	input  i2cRegPkg::memWordT i_memDataIn,
	input  logic               i_memWrEn,
	output i2cRegPkg::memWordT o_memDataOut,
	input  logic               i_smIsBooted,
	input  logic               i_smStartPause,
	output logic               o_smNowPaused,
	input  logic               i_pinSDAIn,
	output logic               o_pinSCLDir,
	output logic               o_pinSDADir,
	output logic               o_intI2C,
	input  logic               i_clk,
	input  logic               i_arstN
);
	import i2cRegPkg::*;
	import i2cBusPkg::*;

	// Register file outputs
	logic     cfgStart, cfgWr, cfgStop, cfgEnable;
	baudT     baud;
	logic     dataWr, dataMsb;
	// Bit engine outputs
	busStateT state;
	logic     halfPhase, atHalf, atMax;
	logic     sampleBit, ackBit, isIdle;

	// ------------------------------------------------------------------------
	// Input side
	i2cRegFile regFile (
		.i_clk        (i_clk),
		.i_arstN      (i_arstN),
		.i_memAddr    (i_memAddr),
		.i_memDataIn  (i_memDataIn),
		.i_memWrEn    (i_memWrEn),
		.i_pinSDAIn   (i_pinSDAIn),
		.i_sampleBit  (sampleBit),
		.i_ackBit     (ackBit),
		.i_isIdle     (isIdle),
		.o_memDataOut (o_memDataOut),
		.o_cfgStart   (cfgStart),
		.o_cfgWr      (cfgWr),
		.o_cfgStop    (cfgStop),
		.o_cfgEnable  (cfgEnable),
		.o_baud       (baud),
		.o_dataWr     (dataWr),
		.o_dataMsb    (dataMsb)
	);

	// Sequencing
	i2cBitEngine bitEngine (
		.i_clk          (i_clk),
		.i_arstN        (i_arstN),
		.i_cfgEnable    (cfgEnable),
		.i_cfgStop      (cfgStop),
		.i_baud         (baud),
		.i_dataWr       (dataWr),
		.i_pinSDAIn     (i_pinSDAIn),
		.i_smIsBooted   (i_smIsBooted),
		.i_smStartPause (i_smStartPause),
		.o_state        (state),
		.o_halfPhase    (halfPhase),
		.o_atHalf       (atHalf),
		.o_atMax        (atMax),
		.o_sampleBit    (sampleBit),
		.o_ackBit       (ackBit),
		.o_isIdle       (isIdle),
		.o_intI2C       (o_intI2C),
		.o_smNowPaused  (o_smNowPaused)
	);

	// Output side
	i2cPinDriver pinDriver (
		.i_clk       (i_clk),
		.i_arstN     (i_arstN),
		.i_cfgEnable (cfgEnable),
		.i_cfgStart  (cfgStart),
		.i_cfgStop   (cfgStop),
		.i_cfgWr     (cfgWr),
		.i_dataMsb   (dataMsb),
		.i_state     (state),
		.i_halfPhase (halfPhase),
		.i_atHalf    (atHalf),
		.i_atMax     (atMax),
		.o_pinSCLDir (o_pinSCLDir),
		.o_pinSDADir (o_pinSDADir)
	);

endmodule

// File: i2cPinDriver.sv
/* I2C pin driver
   Registered open-drain SCL and SDA directions, 1 pulls the line low */
`timescale 1ns/1ns

module i2cPinDriver (
	input  logic                i_clk,
	input  logic                i_arstN,
	input  logic                i_cfgEnable,
	input  logic                i_cfgStart,
	input  logic                i_cfgStop,
	input  logic                i_cfgWr,
	input  logic                i_dataMsb,
	input  i2cBusPkg::busStateT i_state,
	input  logic                i_halfPhase,
	input  logic                i_atHalf,
	input  logic                i_atMax,
	output logic                o_pinSCLDir,
	output logic                o_pinSDADir
);
	import i2cBusPkg::*;

	logic sclQ, sdaQ;
	logic sclNext, sdaNext;
	logic isIdle, isHead, isAck, isTail;

	assign isIdle = (i_state == IDLE);
	assign isHead = (i_state == HEAD);
	assign isAck  = (i_state == ACK);
	assign isTail = (i_state == TAIL);

	// SCL for the coming half, loaded on the last cycle of the current one
	always_comb begin
		if (!i_halfPhase)
			sclNext = isHead ? ~i_cfgStart : (isTail ? ~i_cfgStop : 1'b0);
		else
			sclNext = isTail ? sclQ : 1'b1;   // Every low half pulls; hold at end
	end

	// SDA, changed mid-half
	always_comb begin
		if (isHead)
			sdaNext = i_cfgStart & i_halfPhase;   // Falls while SCL high
		else if (isTail)
			sdaNext = i_cfgStop & ~i_halfPhase;   // Rises while SCL high
		else if (isAck)
			sdaNext = ~i_cfgWr;                   // Master ACK on reads
		else
			sdaNext = i_cfgWr & ~i_dataMsb;       // Released on reads
	end

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			sclQ <= 1'b0;
			sdaQ <= 1'b0;
		end else if (!i_cfgEnable) begin
			sclQ <= 1'b0;                         // Both lines released
			sdaQ <= 1'b0;
		end else begin
			if (!isIdle && i_atMax)
				sclQ <= sclNext;
			if (!isIdle && i_atHalf)
				sdaQ <= sdaNext;
		end
	end

	assign o_pinSCLDir = sclQ;
	assign o_pinSDADir = sdaQ;

endmodule

// File: i2cBitEngine.sv
/* I2C bit engine
   Half-period timing, transfer FSM, ACK capture, end interrupt and pause */
`timescale 1ns/1ns
`include "i2c_consts.svh"

module i2cBitEngine (
	input  logic                i_clk,
	input  logic                i_arstN,
	input  logic                i_cfgEnable,
	input  logic                i_cfgStop,
	input  i2cRegPkg::baudT     i_baud,
	input  logic                i_dataWr,
	input  logic                i_pinSDAIn,
	input  logic                i_smIsBooted,
	input  logic                i_smStartPause,
	output i2cBusPkg::busStateT o_state,
	output logic                o_halfPhase,    // 0 = SCL low half
	output logic                o_atHalf,
	output logic                o_atMax,
	output logic                o_sampleBit,
	output logic                o_ackBit,
	output logic                o_isIdle,
	output logic                o_intI2C,
	output logic                o_smNowPaused
);
	import i2cBusPkg::*;

	baudCntT  cntQ;
	busStateT stateQ;
	logic     halfQ, ackQ, pauseQ;
	logic     busHeldQ;                 // Last transfer left SCL low
	logic     isIdle, isBit, isAck, isTail;
	logic     atHalf, atMax, stateEnd;
	logic     doPause, doStart;

	// State decode
	assign isIdle = (stateQ == IDLE);
	assign isBit  = (stateQ >= `I2C_ST_BIT7) && (stateQ <= `I2C_ST_BIT0);
	assign isAck  = (stateQ == ACK);
	assign isTail = (stateQ == TAIL);

	// Timing points within a half of BAUD+1 cycles
	assign atHalf   = (cntQ == {2'b00, i_baud[14:1]});   // Mid-half
	assign atMax    = (cntQ == {1'b0, i_baud});          // Last cycle of half
	assign stateEnd = ~isIdle & halfQ & atMax;           // Two halves per state

	assign doPause = ~i_smIsBooted | i_smStartPause | pauseQ;
	assign doStart = isIdle & i_dataWr & i_cfgEnable & ~doPause;

	// ------------------------------------------------------------------------
	// Baud counter and half phase
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			cntQ  <= '0;
			halfQ <= 1'b0;
		end else if (isIdle) begin
			cntQ  <= '0;                    // Parked until start
			halfQ <= 1'b0;
		end else if (atMax) begin
			cntQ  <= '0;
			halfQ <= ~halfQ;
		end else begin
			cntQ  <= cntQ + 16'd1;
		end
	end

	// ------------------------------------------------------------------------
	// Transfer FSM
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN)
			stateQ <= IDLE;
		else if (doStart)
			stateQ <= HEAD;
		else if (stateEnd)
			stateQ <= isTail ? IDLE : busStateT'(stateQ + 4'd1);
	end

	// ACK capture, pause, bus hold tracking
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			ackQ     <= 1'b0;
			pauseQ   <= 1'b0;
			busHeldQ <= 1'b0;
		end else begin
			if (isAck && halfQ && atHalf)
				ackQ <= i_pinSDAIn;          // Middle of SCL high
			// Pause only with the bus released
			pauseQ <= i_smStartPause & isIdle & ~busHeldQ;
			if (!i_cfgEnable)
				busHeldQ <= 1'b0;            // Pins forced released
			else if (stateEnd && isTail)
				busHeldQ <= ~i_cfgStop;
		end
	end

	// Outputs
	assign o_state       = stateQ;
	assign o_halfPhase   = halfQ;
	assign o_atHalf      = atHalf;
	assign o_atMax       = atMax;
	assign o_sampleBit   = isBit & halfQ & atHalf;   // Data sampled SCL high
	assign o_ackBit      = ackQ;
	assign o_isIdle      = isIdle;
	assign o_intI2C      = stateEnd & isTail & i_cfgEnable & i_smIsBooted;
	assign o_smNowPaused = pauseQ;

endmodule

// File: i2cRegFile.sv
/* I2C register file
   Decodes bus writes into CTRL, BAUD and DATA and muxes the read word */
`timescale 1ns/1ns
`include "i2c_consts.svh"

module i2cRegFile (
	input  logic               i_clk,
	input  logic               i_arstN,
	input  i2cRegPkg::memAddrT i_memAddr,
	input  i2cRegPkg::memWordT i_memDataIn,
	input  logic               i_memWrEn,
	input  logic               i_pinSDAIn,
	input  logic               i_sampleBit,   // Shift strobe from the engine
	input  logic               i_ackBit,
	input  logic               i_isIdle,
	output i2cRegPkg::memWordT o_memDataOut,
	output logic               o_cfgStart,
	output logic               o_cfgWr,
	output logic               o_cfgStop,
	output logic               o_cfgEnable,
	output i2cRegPkg::baudT    o_baud,
	output logic               o_dataWr,
	output logic               o_dataMsb
);
	import i2cRegPkg::*;

	logic     isCtrlWr, isBaudWr, isDataWr;
	ctrlT     ctrlQ;
	baudT     baudQ;
	dataByteT dataQ;
	memWordT  rdCtrl;

	// ------------------------------------------------------------------------
	// Write decode
	assign isCtrlWr = i_memWrEn & (i_memAddr == `I2C_ADDR_CTRL);
	assign isBaudWr = i_memWrEn & (i_memAddr == `I2C_ADDR_BAUD);
	assign isDataWr = i_memWrEn & (i_memAddr == `I2C_ADDR_DATA);

	// ------------------------------------------------------------------------
	// Registers
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			ctrlQ <= '0;
			baudQ <= '0;
			dataQ <= '0;
		end else begin
			if (isCtrlWr)
				ctrlQ <= i_memDataIn[3:0];
			if (isBaudWr)
				baudQ <= i_memDataIn[15:1];           // LSB dropped
			if (isDataWr)
				dataQ <= i_memDataIn[7:0];            // Bus load wins
			else if (i_sampleBit)
				dataQ <= {dataQ[6:0], i_pinSDAIn};    // MSB first shift
		end
	end

	// Config fan-out
	assign o_cfgStart  = ctrlQ[`I2C_CTRL_START];
	assign o_cfgWr     = ctrlQ[`I2C_CTRL_WR];
	assign o_cfgStop   = ctrlQ[`I2C_CTRL_STOP];
	assign o_cfgEnable = ctrlQ[`I2C_CTRL_EN];
	assign o_baud      = baudQ;
	assign o_dataWr    = isDataWr;                   // Engine builds start from this
	assign o_dataMsb   = dataQ[7];                   // Next bit on SDA

	// ------------------------------------------------------------------------
	// Read-back
	always_comb begin
		rdCtrl                 = '0;
		rdCtrl[`I2C_STAT_IDLE] = i_isIdle;
		rdCtrl[`I2C_STAT_ACK]  = i_ackBit;           // Last ACK slot level
		rdCtrl[3:0]            = ctrlQ;
	end

	always_comb begin
		case (i_memAddr)
			`I2C_ADDR_CTRL: o_memDataOut = rdCtrl;
			`I2C_ADDR_BAUD: o_memDataOut = {baudQ, 1'b0};
			`I2C_ADDR_DATA: o_memDataOut = {8'h00, dataQ};
			default:        o_memDataOut = '0;   // Unmapped
		endcase
	end

endmodule

// File: i2cBusPkg.sv
/* I2C bus sequencing types
   Transfer FSM states and the bit-timing counter width */
package i2cBusPkg;

	// One transfer, in order
	typedef enum logic [3:0] {
		IDLE,
		HEAD,           // Optional START
		BIT7,
		BIT6,
		BIT5,
		BIT4,
		BIT3,
		BIT2,
		BIT1,
		BIT0,
		ACK,            // Acknowledge slot
		TAIL            // Optional STOP
	} busStateT;

	typedef logic [15:0] baudCntT;   // Cycle count within a half

endpackage

// File: i2cRegPkg.sv
/* I2C register map types
   Widths of the bus word, address and register fields */
package i2cRegPkg;

	// Memory bus side
	typedef logic [1:0]  memAddrT;   // Register select
	typedef logic [15:0] memWordT;   // Bus data word

	// Register fields
	typedef logic [14:0] baudT;      // Half bit period, cycles minus one
	typedef logic [7:0]  dataByteT;  // Shift byte
	typedef logic [3:0]  ctrlT;      // START, WR, STOP, EN

endpackage

// File: i2c_consts.svh
/* I2C master peripheral constants
   Register map, CTRL bit positions, status bits and bus state numbers */
`ifndef I2C_CONSTS_SVH
`define I2C_CONSTS_SVH

// Register addresses
`define I2C_ADDR_CTRL  2'd0
`define I2C_ADDR_BAUD  2'd1
`define I2C_ADDR_DATA  2'd2

// CTRL bit positions
`define I2C_CTRL_START 3   // START at the head
`define I2C_CTRL_WR    2   // 1 = write, 0 = read
`define I2C_CTRL_STOP  1   // STOP at the tail
`define I2C_CTRL_EN    0   // Peripheral enable

// Status bits in the CTRL read word
`define I2C_STAT_IDLE  15
`define I2C_STAT_ACK   14

// Bus state numbers, same order as the FSM enum
`define I2C_ST_IDLE    4'd0
`define I2C_ST_HEAD    4'd1
`define I2C_ST_BIT7    4'd2
`define I2C_ST_BIT0    4'd9
`define I2C_ST_ACK     4'd10
`define I2C_ST_TAIL    4'd11

`endif
